// File: clk_meter.f
source/clk_meter_pkg.sv
source/test_reset_sync.sv
source/gray_count_sync.sv
source/measure_window.sv
source/wb_rate_regs.sv
source/clk_meter.sv
tests/clk_meter_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the clock meter testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module clk_meter_tb -f clk_meter.f -o clk_meter_sim || exit 1
# the simulation output is kept in a variable and searched for the pass line
out=$(./obj_dir/clk_meter_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/clk_meter.sv
`timescale 1ns/1ps
`default_nettype none

module clk_meter #(
	// one period of one second at a 100 MHz reference
	parameter int ref_rollover  = 99_999_999,
	// one millisecond sample window at the same reference
	parameter int sample_cycles = 100_000,
	parameter int sync_stages   = 2
) (
	input  logic                   clk_ref,
	input  logic                   async_reset_clk_test,
	input  logic                   clk_test,
	input  clk_meter_pkg::wb_req_t wb_req,
	output clk_meter_pkg::wb_rsp_t wb_rsp
);

	// reference domain clear pulse and its test domain copy
	logic win_clear;
	logic test_clear;

	// synchronized count, latest result and the pause control
	logic [clk_meter_pkg::rate_width-1:0] count_ref;
	clk_meter_pkg::rate_result_t          result;
	logic                                 meas_enable;

	// ==============================
	// test clock side
	// ==============================

	// carries the per-window clear onto clk_test
	test_reset_sync #(
		.sync_stages(sync_stages)
	) test_reset_sync_i (
		.clk_test            (clk_test),
		.async_reset_clk_test(async_reset_clk_test),
		.win_clear           (win_clear),
		.test_clear          (test_clear)
	);

	// counts test edges and hands them back in gray code
	gray_count_sync #(
		.sync_stages(sync_stages)
	) gray_count_sync_i (
		.clk_test            (clk_test),
		.clk_ref             (clk_ref),
		.async_reset_clk_test(async_reset_clk_test),
		.test_clear          (test_clear),
		.count_ref           (count_ref)
	);

	// ==============================
	// reference clock side
	// ==============================

	measure_window #(
		.ref_rollover (ref_rollover),
		.sample_cycles(sample_cycles)
	) measure_window_i (
		.clk_ref             (clk_ref),
		.async_reset_clk_test(async_reset_clk_test),
		.meas_enable         (meas_enable),
		.count_ref           (count_ref),
		.win_clear           (win_clear),
		.result              (result)
	);

	// host access to the rate, status and control words
	wb_rate_regs wb_rate_regs_i (
		.clk_ref             (clk_ref),
		.async_reset_clk_test(async_reset_clk_test),
		.wb_req              (wb_req),
		.wb_rsp              (wb_rsp),
		.result              (result),
		.meas_enable         (meas_enable)
	);

endmodule

`default_nettype wire

// File: source/clk_meter_pkg.sv
`default_nettype none

package clk_meter_pkg;

	// ==============================
	// widths
	// ==============================

	// test counter and captured rate share one width
	localparam int rate_width = 24;
	// completed-measurement counter, wraps around
	localparam int seq_width = 8;

	// wishbone word address and data word
	typedef logic [3:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// ==============================
	// encodings
	// ==============================

	// register word addresses, anything else reads zero
	typedef enum logic [3:0] {
		reg_rate   = 4'd0,
		reg_status = 4'd1,
		reg_ctrl   = 4'd2
	} reg_addr_e;

	// window sequencer states in the reference domain
	typedef enum logic [1:0] {
		win_clear = 2'd0,
		win_count = 2'd1,
		win_hold  = 2'd2
	} win_state_e;

	// ==============================
	// bundles
	// ==============================

	// host request on the wishbone classic port
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	// slave response, dat is only meaningful while ack is high
	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	// one published measurement
	typedef struct packed {
		logic [rate_width-1:0] value;
		logic [seq_width-1:0]  seq;
		logic                  valid;
	} rate_result_t;

endpackage

`default_nettype wire

// File: source/gray_count_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_count_sync #(
	parameter int sync_stages = 2
) (
	input  logic                                 clk_test,
	input  logic                                 clk_ref,
	input  logic                                 async_reset_clk_test,
	input  logic                                 test_clear,
	output logic [clk_meter_pkg::rate_width-1:0] count_ref
);

	// binary to gray, a single shift and xor
	function automatic logic [clk_meter_pkg::rate_width-1:0] bin_to_gray(
		input logic [clk_meter_pkg::rate_width-1:0] bin
	);
		return bin ^ (bin >> 1);
	endfunction

	// gray to binary, each bit is the xor of all gray bits above and including it
	function automatic logic [clk_meter_pkg::rate_width-1:0] gray_to_bin(
		input logic [clk_meter_pkg::rate_width-1:0] gray
	);
		logic [clk_meter_pkg::rate_width-1:0] bin;
		bin[clk_meter_pkg::rate_width-1] = gray[clk_meter_pkg::rate_width-1];
		for (int i = clk_meter_pkg::rate_width - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	// ==============================
	// test clock domain
	// ==============================

	// only the gray form is stored, so every flop seen by the other domain
	// changes in at most one bit per edge
	logic [clk_meter_pkg::rate_width-1:0] gray_q;

	// the clear is asserted asynchronously and released in step with clk_test
	always_ff @(posedge clk_test or posedge test_clear) begin
		if (test_clear) begin
			gray_q <= '0;
		end else begin
			// step in binary, then store the gray code of the next value
			gray_q <= bin_to_gray(gray_to_bin(gray_q) + clk_meter_pkg::rate_width'(1));
		end
	end

	// ==============================
	// reference clock domain
	// ==============================

	// stage 0 is the metastable one, the top stage is safe to decode
	logic [sync_stages-1:0][clk_meter_pkg::rate_width-1:0] gray_sync;

	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			gray_sync <= '0;
			count_ref <= '0;
		end else begin
			gray_sync <= {gray_sync[sync_stages-2:0], gray_q};
			// decode is registered, which adds the one extra cycle of lag
			count_ref <= gray_to_bin(gray_sync[sync_stages-1]);
		end
	end

	// a multi-bit step here would let the reference side capture a torn value
	gray_one_bit: assert property (
		@(posedge clk_test) disable iff (test_clear)
		$countones(gray_q ^ $past(gray_q)) <= 1
	);

endmodule

`default_nettype wire

// File: source/measure_window.sv
`timescale 1ns/1ps
`default_nettype none

module measure_window #(
	parameter int ref_rollover  = 63,
	parameter int sample_cycles = 40
) (
	input  logic                                 clk_ref,
	input  logic                                 async_reset_clk_test,
	input  logic                                 meas_enable,
	input  logic [clk_meter_pkg::rate_width-1:0] count_ref,
	output logic                                 win_clear,
	output clk_meter_pkg::rate_result_t          result
);

	// wide enough to hold the last index of a period
	localparam int cnt_width = $clog2(ref_rollover + 1);

	clk_meter_pkg::win_state_e state;
	logic [cnt_width-1:0]      period_cnt;
	logic                      capture;

	// sample point of the window, only while counting and not paused
	assign capture = (state == clk_meter_pkg::win_count) && meas_enable &&
		(period_cnt == cnt_width'(sample_cycles));

	// ==============================
	// period sequencer
	// ==============================

	// win_clear is a flop of its own so the async preset downstream never sees a glitch
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			state      <= clk_meter_pkg::win_clear;
			period_cnt <= '0;
			win_clear  <= 1'b1;
		end else if (!meas_enable) begin
			// paused, park in clear so a resume starts a full period
			state      <= clk_meter_pkg::win_clear;
			period_cnt <= '0;
			win_clear  <= 1'b1;
		end else begin
			case (state)
				clk_meter_pkg::win_clear: begin
					// index 0 of the period was this cycle
					state      <= clk_meter_pkg::win_count;
					period_cnt <= cnt_width'(1);
					win_clear  <= 1'b0;
				end
				clk_meter_pkg::win_count: begin
					period_cnt <= period_cnt + cnt_width'(1);
					if (capture) begin
						state <= clk_meter_pkg::win_hold;
					end
				end
				clk_meter_pkg::win_hold: begin
					// wait out the rest of the period, then clear again
					if (period_cnt == cnt_width'(ref_rollover)) begin
						state      <= clk_meter_pkg::win_clear;
						period_cnt <= '0;
						win_clear  <= 1'b1;
					end else begin
						period_cnt <= period_cnt + cnt_width'(1);
					end
				end
				default: begin
					state      <= clk_meter_pkg::win_clear;
					period_cnt <= '0;
					win_clear  <= 1'b1;
				end
			endcase
		end
	end

	// ==============================
	// result publication
	// ==============================

	// all ones until the first window completes, then the latest count
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			result.value <= '1;
			result.seq   <= '0;
			result.valid <= 1'b0;
		end else if (capture) begin
			result.value <= count_ref;
			result.seq   <= result.seq + clk_meter_pkg::seq_width'(1);
			result.valid <= 1'b1;
		end
	end

	// a capture lands only while counting and exactly sample_cycles after the clear cycle
	capture_in_count: assert property (
		@(posedge clk_ref) disable iff (async_reset_clk_test)
		capture |-> (state == clk_meter_pkg::win_count) && $past(win_clear, sample_cycles)
	);

endmodule

`default_nettype wire

// File: source/test_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module test_reset_sync #(
	parameter int sync_stages = 2
) (
	input  logic clk_test,
	input  logic async_reset_clk_test,
	input  logic win_clear,
	output logic test_clear
);

	// all ones means clear is held, zeros walk in from bit 0 on release
	logic [sync_stages-1:0] clear_chain;

	// either source presets the whole chain at once, without waiting for clk_test
	// if clk_test is dead the chain never drains, so the counter stays at zero
	always_ff @(posedge clk_test or posedge async_reset_clk_test or posedge win_clear) begin
		if (async_reset_clk_test || win_clear) begin
			clear_chain <= '1;
		end else begin
			clear_chain <= {clear_chain[sync_stages-2:0], 1'b0};
		end
	end

	// the last stage is the one that leaves this block
	assign test_clear = clear_chain[sync_stages-1];

	// a clear seen on any of the last sync_stages test edges must still be held here
	// this ties the window sequencer's pulse to what the counter actually sees
	clear_held: assert property (
		@(posedge clk_test) disable iff (async_reset_clk_test)
		win_clear |-> test_clear [*sync_stages]
	);

endmodule

`default_nettype wire

// File: source/wb_rate_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_rate_regs (
	input  logic                         clk_ref,
	input  logic                         async_reset_clk_test,
	input  clk_meter_pkg::wb_req_t       wb_req,
	output clk_meter_pkg::wb_rsp_t       wb_rsp,
	input  clk_meter_pkg::rate_result_t  result,
	output logic                         meas_enable
);

	logic                    ack_q;
	logic                    req;
	clk_meter_pkg::wb_data_t rd_mux;
	clk_meter_pkg::wb_data_t rd_data;
	clk_meter_pkg::reg_addr_e reg_addr;

	// a request is only taken once the previous ack has dropped
	assign req = wb_req.cyc && wb_req.stb && !ack_q;

	// unknown addresses fall through to the default arm below
	assign reg_addr = clk_meter_pkg::reg_addr_e'(wb_req.adr);

	// ==============================
	// read mux
	// ==============================

	always_comb begin
		case (reg_addr)
			clk_meter_pkg::reg_rate: begin
				// zero-extended up to the bus width
				rd_mux = clk_meter_pkg::wb_data_t'(result.value);
			end
			clk_meter_pkg::reg_status: begin
				// valid in bit 0, seq in bits 15 to 8
				rd_mux = {16'd0, result.seq, 7'd0, result.valid};
			end
			clk_meter_pkg::reg_ctrl: begin
				rd_mux = {31'd0, meas_enable};
			end
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	// ==============================
	// handshake and control
	// ==============================

	// ack follows the request by one clock and lasts exactly one clock
	// measuring runs by default, the host may pause it through ctrl
	always_ff @(posedge clk_ref or posedge async_reset_clk_test) begin
		if (async_reset_clk_test) begin
			ack_q       <= 1'b0;
			meas_enable <= 1'b1;
		end else begin
			ack_q <= req;
			// the write lands on the same edge that raises ack
			if (req && wb_req.we && (reg_addr == clk_meter_pkg::reg_ctrl)) begin
				meas_enable <= wb_req.dat[0];
			end
		end
	end

	// read data is sampled with the request and held through ack
	always_ff @(posedge clk_ref) begin
		if (req) begin
			rd_data <= rd_mux;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_data;

	// the host must keep cyc and stb up until it sees ack, and ack never lasts two cycles
	ack_in_cycle: assert property (
		@(posedge clk_ref) disable iff (async_reset_clk_test)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb && !$past(wb_rsp.ack))
	);

endmodule

`default_nettype wire

// File: tests/clk_meter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clk_meter_tb;

	localparam int ref_rollover  = 63;
	localparam int sample_cycles = 40;
	localparam int sync_stages   = 2;
	localparam int case_count    = 5;
	// a partial window and two full ones per entry, plus room for reset and bus traffic
	localparam int cycle_limit = case_count * 3 * (ref_rollover + 1) + 200;

	logic                   clk_ref = 1'b0;
	logic                   clk_test = 1'b0;
	logic                   async_reset_clk_test;
	clk_meter_pkg::wb_req_t wb_req;
	clk_meter_pkg::wb_rsp_t wb_rsp;

	// half period of the test clock in ns, zero stops it
	int test_half = 0;
	int cycle_count = 0;
	// last seq seen by the host and the reference cycle it was seen in
	logic [clk_meter_pkg::seq_width-1:0] last_seq = '0;
	int                                  last_seq_cycle = 0;

	// stimulus table, one test clock period and one expected rate per entry
	string                                case_name [case_count];
	int                                   case_period [case_count];
	logic [clk_meter_pkg::rate_width-1:0] case_rate [case_count];

	clk_meter #(
		.ref_rollover (ref_rollover),
		.sample_cycles(sample_cycles),
		.sync_stages  (sync_stages)
	) clk_meter_i (
		.clk_ref             (clk_ref),
		.async_reset_clk_test(async_reset_clk_test),
		.clk_test            (clk_test),
		.wb_req              (wb_req),
		.wb_rsp              (wb_rsp)
	);

	// ==============================
	// clocks and timeout
	// ==============================

	// 100 ns reference
	always #50 clk_ref = ~clk_ref;

	// after a restart the test clock runs 7 ns off the 25 ns grid
	// so its edges never coincide with reference edges
	always begin
		if (test_half == 0) begin
			clk_test = 1'b0;
			@(test_half);
			#7;
		end else begin
			#(test_half) clk_test = ~clk_test;
		end
	end

	always @(posedge clk_ref) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure("timeout, the tests did not finish within the cycle limit");
		end
	end

	// ==============================
	// helpers
	// ==============================

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "stopping at the first failure");
	endtask

	// the counter runs from the end of the clear cycle up to the point whose value
	// reaches the sample after sync_stages+1 cycles, and the release eats sync_stages edges
	function automatic logic [clk_meter_pkg::rate_width-1:0] rate_for(input int period_ns);
		int open_ns;
		open_ns = (sample_cycles - sync_stages - 1) * 100;
		if (period_ns == 0) begin
			return '0;
		end
		return clk_meter_pkg::rate_width'(open_ns / period_ns - sync_stages);
	endfunction

	task automatic load_cases();
		case_name[0] = "slow quarter";
		case_period[0] = 400;
		case_name[1] = "slow half";
		case_period[1] = 200;
		case_name[2] = "equal";
		case_period[2] = 100;
		case_name[3] = "fast double";
		case_period[3] = 50;
		// stopped clock goes last, the clock is never restarted
		case_name[4] = "stopped";
		case_period[4] = 0;
		for (int i = 0; i < case_count; i++) begin
			case_rate[i] = rate_for(case_period[i]);
		end
	endtask

	// one classic cycle, the request stays up through the edge that ends ack
	task automatic bus_transfer(input logic we, input clk_meter_pkg::wb_addr_t adr,
			input clk_meter_pkg::wb_data_t wdata, output clk_meter_pkg::wb_data_t rdata);
		int waited;
		@(negedge clk_ref);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
		waited = 0;
		@(negedge clk_ref);
		while (!wb_rsp.ack) begin
			waited++;
			if (waited >= 4) begin
				stop_with_failure("no ack from the slave within 4 cycles");
			end
			@(negedge clk_ref);
		end
		rdata = wb_rsp.dat;
		@(negedge clk_ref);
		wb_req = '0;
		// idle gap of 0 to 3 cycles
		repeat ($urandom % 4) @(negedge clk_ref);
	endtask

	task automatic bus_read(input clk_meter_pkg::wb_addr_t adr,
			output clk_meter_pkg::wb_data_t data);
		bus_transfer(1'b0, adr, '0, data);
	endtask

	task automatic bus_write(input clk_meter_pkg::wb_addr_t adr,
			input clk_meter_pkg::wb_data_t data);
		clk_meter_pkg::wb_data_t unused;
		bus_transfer(1'b1, adr, data, unused);
	endtask

	// seq must never go back and never run ahead of the periods that passed
	task automatic track_seq(input logic [clk_meter_pkg::seq_width-1:0] seq);
		int periods;
		int advance;
		periods = (cycle_count - last_seq_cycle) / (ref_rollover + 1) + 1;
		if (seq < last_seq) begin
			stop_with_failure($sformatf("seq went backwards from %0d to %0d", last_seq, seq));
		end
		advance = seq - last_seq;
		if (advance > periods) begin
			stop_with_failure($sformatf("seq advanced by %0d within %0d periods",
				advance, periods));
		end
		last_seq = seq;
		last_seq_cycle = cycle_count;
	endtask

	task automatic read_rate(output logic [clk_meter_pkg::rate_width-1:0] rate);
		clk_meter_pkg::wb_data_t data;
		bus_read(clk_meter_pkg::reg_rate, data);
		rate = data[clk_meter_pkg::rate_width-1:0];
	endtask

	task automatic read_status(output logic valid,
			output logic [clk_meter_pkg::seq_width-1:0] seq);
		clk_meter_pkg::wb_data_t data;
		bus_read(clk_meter_pkg::reg_status, data);
		valid = data[0];
		seq = data[15:8];
		track_seq(seq);
	endtask

	// polls status until the given number of windows have completed
	task automatic wait_windows(input int windows, output logic valid,
			output logic [clk_meter_pkg::seq_width-1:0] seq);
		logic [clk_meter_pkg::seq_width-1:0] start;
		read_status(valid, start);
		seq = start;
		while (int'(seq) - int'(start) < windows) begin
			read_status(valid, seq);
		end
	endtask

	// ==============================
	// compare tasks
	// ==============================

	task automatic check_rate(input string name, input logic [clk_meter_pkg::rate_width-1:0] exp,
			input logic [clk_meter_pkg::rate_width-1:0] act, input int tolerance);
		int diff;
		diff = (act > exp) ? int'(act - exp) : int'(exp - act);
		if (diff > tolerance) begin
			stop_with_failure($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input logic exp_valid,
			input logic [clk_meter_pkg::seq_width-1:0] exp_seq, input logic act_valid,
			input logic [clk_meter_pkg::seq_width-1:0] act_seq);
		if (act_valid !== exp_valid || act_seq !== exp_seq) begin
			stop_with_failure($sformatf("** Error %s: expected valid %0b seq %0d, %s",
				name, exp_valid, exp_seq,
				$sformatf("actual valid %0b seq %0d", act_valid, act_seq)));
		end
	endtask

	task automatic check_word(input string name, input clk_meter_pkg::wb_data_t exp,
			input clk_meter_pkg::wb_data_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		logic [clk_meter_pkg::rate_width-1:0] rate;
		logic [clk_meter_pkg::rate_width-1:0] held_rate;
		logic [clk_meter_pkg::seq_width-1:0]  seq;
		logic [clk_meter_pkg::seq_width-1:0]  held_seq;
		logic                                 valid;
		clk_meter_pkg::wb_data_t              data;
		void'($urandom(32'h1222));
		async_reset_clk_test = 1'b1;
		wb_req = '0;
		load_cases();
		repeat (16) @(negedge clk_ref);
		async_reset_clk_test = 1'b0;

		// nothing has been measured yet
		read_rate(rate);
		check_rate("rate after reset", '1, rate, 0);
		read_status(valid, seq);
		check_status("status after reset", 1'b0, '0, valid, seq);
		bus_read(clk_meter_pkg::reg_ctrl, data);
		check_word("ctrl after reset", 32'd1, data);

		// the window in progress straddles each switch, so the second one is checked
		for (int i = 0; i < case_count; i++) begin
			@(negedge clk_ref);
			test_half = case_period[i] / 2;
			wait_windows(2, valid, seq);
			read_rate(rate);
			check_rate(case_name[i], case_rate[i], rate, (case_period[i] == 0) ? 0 : 3);
		end

		// pause, then poke the unused and read-only words while nothing moves
		bus_write(clk_meter_pkg::reg_ctrl, 32'd0);
		read_status(valid, held_seq);
		read_rate(held_rate);
		bus_read(clk_meter_pkg::reg_ctrl, data);
		check_word("ctrl while paused", 32'd0, data);
		bus_read(4'hf, data);
		check_word("unused address", 32'd0, data);
		bus_write(clk_meter_pkg::reg_rate, 32'h00ab_cdef);
		read_rate(rate);
		check_rate("rate after write to rate", held_rate, rate, 0);
		repeat (2 * (ref_rollover + 1)) @(negedge clk_ref);
		read_status(valid, seq);
		check_status("status while paused", 1'b1, held_seq, valid, seq);
		read_rate(rate);
		check_rate("rate while paused", held_rate, rate, 0);

		// resume starts a full period and the next window completes
		bus_write(clk_meter_pkg::reg_ctrl, 32'd1);
		wait_windows(1, valid, seq);
		check_status("status after resume", 1'b1, held_seq + 1'b1, valid, seq);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
